// File: Makefile
TOP := axi_udp_cmd_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+verilog
verilog/udp_cmd_pkg.sv
verilog/udp_cmd_parser.sv
verilog/udp_cmd_queue.sv
verilog/axi_cmd_executor.sv
verilog/udp_reply_sender.sv
verilog/axi_udp_cmd.sv
testbench/axi_udp_cmd_assertions.sv
testbench/axi_udp_cmd_tb.sv

// File: testbench/axi_udp_cmd_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module axi_udp_cmd_assertions (
    input wire gmii_rx_clk,
    input wire arst_n,
    input wire aw_valid,
    input wire aw_ready,
    input wire w_valid,
    input wire w_ready,
    input wire ar_valid,
    input wire ar_ready,
    input wire rsp_req,
    input wire rsp_ack,
    input wire tx_start_en
);

    aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
        aw_valid && !aw_ready |=> aw_valid) else $error("aw_valid dropped before aw_ready");

    w_hold: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
        w_valid && !w_ready |=> w_valid) else $error("w_valid dropped before w_ready");

    ar_hold: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
        ar_valid && !ar_ready |=> ar_valid) else $error("ar_valid dropped before ar_ready");

    // four-phase request side
    req_hold: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
        rsp_req && !rsp_ack |=> rsp_req) else $error("rsp_req dropped before rsp_ack");

    start_pulse: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
        tx_start_en |=> !tx_start_en) else $error("tx_start_en longer than one cycle");

endmodule

bind axi_udp_cmd axi_udp_cmd_assertions u_assertions (
    .gmii_rx_clk (gmii_rx_clk),
    .arst_n      (arst_n     ),
    .aw_valid    (aw_valid   ),
    .aw_ready    (aw_ready   ),
    .w_valid     (w_valid    ),
    .w_ready     (w_ready    ),
    .ar_valid    (ar_valid   ),
    .ar_ready    (ar_ready   ),
    .rsp_req     (rsp_req    ),
    .rsp_ack     (rsp_ack    ),
    .tx_start_en (tx_start_en)
);

`default_nettype wire

// File: testbench/axi_udp_cmd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_udp_cmd_tb;
    import udp_cmd_pkg::*;

    logic       clk;
    logic       arst_n;
    logic       rec_en;
    word_t      rec_data;
    logic       rec_pkt_done;
    logic       tx_start_en;
    byte_num_t  tx_byte_num;
    logic       tx_req;
    word_t      tx_data;
    logic       tx_done;
    addr_t      aw_addr;
    logic       aw_valid;
    logic       aw_ready;
    word_t      w_data;
    logic       w_valid;
    logic       w_ready;
    resp_t      b_resp;
    logic       b_valid;
    logic       b_ready;
    addr_t      ar_addr;
    logic       ar_valid;
    logic       ar_ready;
    word_t      r_data;
    resp_t      r_resp;
    logic       r_valid;
    logic       r_ready;
    logic [7:0] udp_led;

    word_t      mem [16];        // axi slave storage by word index
    logic       axi_stall;
    logic       wr_err;
    logic       got_aw;
    logic       got_w;
    logic       rd_fire;
    logic       b_fire;
    logic       r_fire;
    addr_t      wr_addr;
    addr_t      rd_addr;
    word_t      wr_data;
    word_t      pkt [$];
    word_t      rep_words [$];
    byte_num_t  rep_bytes [$];
    integer     seed = 32'hf57576f6;
    integer     errors = 0;

    assign aw_ready = !axi_stall;
    assign w_ready  = !axi_stall;
    assign ar_ready = !axi_stall;

    axi_udp_cmd DUT (.*, .gmii_rx_clk(clk));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // axi slave samples transfers on the edge and responds 1 ns later
    initial begin
        b_valid = 1'b0;
        r_valid = 1'b0;
        b_resp  = 2'b00;
        r_resp  = 2'b00;
        r_data  = '0;
        got_aw  = 1'b0;
        got_w   = 1'b0;
        for (int i = 0; i < 16; i++) mem[i] = 32'h5a5a0000 ^ (i * 32'h00010203);
        forever begin
            @(posedge clk);
            b_fire  = b_valid && b_ready;
            r_fire  = r_valid && r_ready;
            rd_fire = ar_valid && ar_ready;
            if (aw_valid && aw_ready) begin
                got_aw  = 1'b1;
                wr_addr = aw_addr;
            end
            if (w_valid && w_ready) begin
                got_w   = 1'b1;
                wr_data = w_data;
            end
            if (rd_fire) rd_addr = ar_addr;
            #1;
            if (b_fire) b_valid = 1'b0;
            if (r_fire) r_valid = 1'b0;
            if (got_aw && got_w) begin
                mem[wr_addr[5:2]] = wr_data;
                got_aw  = 1'b0;
                got_w   = 1'b0;
                b_valid = 1'b1;
                b_resp  = wr_err ? 2'b10 : 2'b00; // slverr on request
            end
            if (rd_fire) begin
                r_valid = 1'b1;
                r_data  = mem[rd_addr[5:2]];
                r_resp  = 2'b00;
            end
        end
    end

    // udp transmitter sends one word per tx_req
    initial begin
        byte_num_t nb;
        tx_req  = 1'b0;
        tx_done = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (tx_start_en) begin
                nb = tx_byte_num;
                for (int k = 0; k < nb / 4; k++) begin
                    tx_req = 1'b1;
                    @(posedge clk);
                    #1 tx_req = 1'b0;
                    rep_words.push_back(tx_data);
                end
                tx_done = 1'b1;
                @(posedge clk);
                #1 tx_done = 1'b0;
                rep_bytes.push_back(nb);
            end
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            fail_now($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            errors++;
            fail_now($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_byte_num(input string name, input byte_num_t exp,
                                  input byte_num_t act);
        if (exp !== act) begin
            errors++;
            fail_now($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] exp,
                               input logic [7:0] act);
        if (exp !== act) begin
            errors++;
            fail_now($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    function automatic word_t make_header(input opcode_t op, input logic [23:0] tag);
        return {op, tag};
    endfunction

    task automatic send_packet();
        for (int i = 0; i < pkt.size(); i++) begin
            @(posedge clk);
            #1;
            rec_en   = 1'b1;
            rec_data = pkt[i];
        end
        @(posedge clk);
        #1;
        rec_en       = 1'b0;
        rec_pkt_done = 1'b1;
        @(posedge clk);
        #1 rec_pkt_done = 1'b0;
        pkt.delete();
    endtask

    task automatic wait_reply(output word_t hdr, output addr_t addr, output word_t data,
                              output byte_num_t nb);
        int cnt;
        cnt = 0;
        while (rep_bytes.size() == 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > 2000) fail_now("timeout: no reply packet from the DUT");
        end
        nb   = rep_bytes.pop_front();
        hdr  = rep_words.pop_front();
        addr = rep_words.pop_front();
        data = (nb == 16'd12) ? rep_words.pop_front() : '0;
    endtask

    task automatic write_then_read();
        word_t hdr, data, wd, hw, hr;
        addr_t addr;
        byte_num_t nb;
        wd = $random(seed);
        hw = make_header(OP_WRITE, 24'h000101);
        hr = make_header(OP_READ, 24'h000102);
        pkt = '{hw, 32'h8, wd};
        send_packet();
        wait_reply(hdr, addr, data, nb);
        check_byte_num("wr_rd write bytes", 16'd8, nb);
        check_word("wr_rd write header", {hw[31:2], 2'b00}, hdr);
        check_word("wr_rd write addr", 32'h8, addr);
        check_word("wr_rd memory", wd, mem[2]);
        #1 axi_stall = 1'b1;        // ar held off for a few cycles
        pkt = '{hr, 32'h8};
        send_packet();
        repeat (3) @(posedge clk);
        #1 axi_stall = 1'b0;
        wait_reply(hdr, addr, data, nb);
        check_byte_num("wr_rd read bytes", 16'd12, nb);
        check_resp("wr_rd read resp", 2'b00, hdr[1:0]);
        check_word("wr_rd read data", wd, data);
    endtask

    task automatic three_cmd_packet();
        word_t hdr, data, h [3];
        addr_t addr;
        byte_num_t nb;
        logic [7:0] led0;
        led0 = udp_led;
        h[0] = make_header(OP_WRITE, 24'h0a0b04);
        h[1] = make_header(OP_READ, 24'h0a0b08);
        h[2] = make_header(OP_READ, 24'h0a0b0c);
        pkt = '{h[0], 32'h10, 32'hcafe0010, h[1], 32'h10, h[2], 32'h14};
        send_packet();
        for (int i = 0; i < 3; i++) begin
            wait_reply(hdr, addr, data, nb);
            check_word($sformatf("multi tag %0d", i), {h[i][31:2], 2'b00}, hdr);
            if (i == 1) check_word("multi read back", 32'hcafe0010, data);
            if (i == 2) check_word("multi read old", mem[5], data);
        end
        check_count("multi led", led0 + 8'd3, udp_led);
    endtask

    task automatic malformed_packets();
        word_t hdr, data, hr;
        addr_t addr;
        byte_num_t nb;
        logic [7:0] led0;
        led0 = udp_led;
        hr = make_header(OP_READ, 24'h33cc10);
        pkt = '{32'h07123454};      // unknown opcode
        send_packet();
        pkt = '{make_header(OP_WRITE, 24'h000200), 32'h1c};   // cut after address
        send_packet();
        pkt = '{hr, 32'h1c};
        send_packet();
        wait_reply(hdr, addr, data, nb);
        check_word("bad header", {hr[31:2], 2'b00}, hdr);
        check_word("bad data", mem[7], data);
        check_count("bad led", led0 + 8'd1, udp_led);
    endtask

    task automatic write_slverr();
        word_t hdr, data;
        addr_t addr;
        byte_num_t nb;
        wr_err = 1'b1;
        pkt = '{make_header(OP_WRITE, 24'h00e001), 32'h20, 32'h1234abcd};
        send_packet();
        wait_reply(hdr, addr, data, nb);
        wr_err = 1'b0;
        check_resp("slverr resp", 2'b10, hdr[1:0]);
        check_byte_num("slverr bytes", 16'd8, nb);
    endtask

    task automatic stalled_axi_drop();
        word_t hdr, data, h [7];
        addr_t addr;
        byte_num_t nb;
        logic [7:0] led0;
        led0 = udp_led;
        @(posedge clk);
        #1 axi_stall = 1'b1;
        for (int i = 0; i < 7; i++) begin
            h[i] = make_header(OP_WRITE, 24'h00f000 + 24'(i * 4));
            pkt.push_back(h[i]);
            pkt.push_back(32'h4 * i);
            pkt.push_back($random(seed));
        end
        send_packet();
        repeat (4) @(posedge clk);
        #1 axi_stall = 1'b0;
        for (int i = 0; i < 5; i++) begin
            wait_reply(hdr, addr, data, nb);
            check_word($sformatf("backpressure tag %0d", i), {h[i][31:2], 2'b00}, hdr);
        end
        repeat (40) @(posedge clk);
        if (rep_bytes.size() != 0) fail_now("reply received for a dropped command");
        check_count("backpressure led", led0 + 8'd5, udp_led);
    endtask

    initial begin
        arst_n       = 1'b0;
        rec_en       = 1'b0;
        rec_data     = '0;
        rec_pkt_done = 1'b0;
        axi_stall    = 1'b0;
        wr_err       = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        write_then_read();
        three_cmd_packet();
        malformed_packets();
        write_slverr();
        stalled_axi_drop();
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/axi_cmd_executor.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cmd_executor (
    input  wire                     gmii_rx_clk,
    input  wire                     arst_n,
    input  wire                     empty,
    input  wire                     head_is_write,
    input  wire udp_cmd_pkg::word_t head_tag,
    input  wire udp_cmd_pkg::addr_t head_addr,
    input  wire udp_cmd_pkg::word_t head_data,
    output logic                    pop,
    output udp_cmd_pkg::addr_t      aw_addr,
    output logic                    aw_valid,
    input  wire                     aw_ready,
    output udp_cmd_pkg::word_t      w_data,
    output logic                    w_valid,
    input  wire                     w_ready,
    input  wire udp_cmd_pkg::resp_t b_resp,
    input  wire                     b_valid,
    output logic                    b_ready,
    output udp_cmd_pkg::addr_t      ar_addr,
    output logic                    ar_valid,
    input  wire                     ar_ready,
    input  wire udp_cmd_pkg::word_t r_data,
    input  wire udp_cmd_pkg::resp_t r_resp,
    input  wire                     r_valid,
    output logic                    r_ready,
    output logic                    rsp_req,
    input  wire                     rsp_ack,
    output logic                    rsp_is_write,
    output udp_cmd_pkg::word_t      rsp_tag,
    output udp_cmd_pkg::resp_t      rsp_resp,
    output udp_cmd_pkg::addr_t      rsp_addr,
    output udp_cmd_pkg::word_t      rsp_data,
    output logic                    executed
);
    import udp_cmd_pkg::*;

    exec_state_t state;
    addr_t       cmd_addr;
    logic        aw_done;
    logic        w_done;

    // head is taken into the executor, freeing its queue slot
    assign pop      = (state == IDLE) && !empty && !rsp_ack;
    assign b_ready  = (state == WR_RESP);
    assign r_ready  = (state == RD_DATA);
    assign aw_addr  = cmd_addr;
    assign ar_addr  = cmd_addr;
    assign rsp_addr = cmd_addr;
    assign aw_done  = !aw_valid || aw_ready; // done now or earlier
    assign w_done   = !w_valid || w_ready;

    always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
            rsp_req  <= 1'b0;
            executed <= 1'b0;
        end else begin
            executed <= 1'b0;
            case (state)
                IDLE: begin
                    if (pop && head_is_write) begin
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                        state    <= WR_ADDR;
                    end else if (pop) begin
                        ar_valid <= 1'b1;
                        state    <= RD_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (aw_ready) aw_valid <= 1'b0;
                    if (w_ready) w_valid <= 1'b0;
                    if (aw_done && w_done) state <= WR_RESP;
                end
                WR_RESP: begin
                    if (b_valid) begin
                        rsp_req  <= 1'b1;
                        executed <= 1'b1;
                        state    <= HANDOFF;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        state    <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_valid) begin
                        rsp_req  <= 1'b1;
                        executed <= 1'b1;
                        state    <= HANDOFF;
                    end
                end
                HANDOFF: begin
                    if (rsp_req) begin
                        if (rsp_ack) rsp_req <= 1'b0;
                    end else if (!rsp_ack) begin
                        state <= IDLE; // four-phase complete
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (pop) begin
            cmd_addr     <= head_addr;
            w_data       <= head_data;
            rsp_tag      <= head_tag;
            rsp_is_write <= head_is_write;
        end
        if (b_ready && b_valid) rsp_resp <= b_resp;
        if (r_ready && r_valid) begin
            rsp_resp <= r_resp;
            rsp_data <= r_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/axi_udp_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module axi_udp_cmd (
    input  wire                     gmii_rx_clk,
    input  wire                     arst_n,
    input  wire                     rec_en,
    input  wire udp_cmd_pkg::word_t rec_data,
    input  wire                     rec_pkt_done,
    output logic                    tx_start_en,
    output udp_cmd_pkg::byte_num_t  tx_byte_num,
    input  wire                     tx_req,
    output udp_cmd_pkg::word_t      tx_data,
    input  wire                     tx_done,
    output udp_cmd_pkg::addr_t      aw_addr,
    output logic                    aw_valid,
    input  wire                     aw_ready,
    output udp_cmd_pkg::word_t      w_data,
    output logic                    w_valid,
    input  wire                     w_ready,
    input  wire udp_cmd_pkg::resp_t b_resp,
    input  wire                     b_valid,
    output logic                    b_ready,
    output udp_cmd_pkg::addr_t      ar_addr,
    output logic                    ar_valid,
    input  wire                     ar_ready,
    input  wire udp_cmd_pkg::word_t r_data,
    input  wire udp_cmd_pkg::resp_t r_resp,
    input  wire                     r_valid,
    output logic                    r_ready,
    output logic [7:0]              udp_led
);
    import udp_cmd_pkg::*;

    logic  push;
    logic  push_is_write;
    word_t push_tag;
    addr_t push_addr;
    word_t push_data;
    logic  full;
    logic  empty;
    logic  head_is_write;
    word_t head_tag;
    addr_t head_addr;
    word_t head_data;
    logic  pop;
    logic  rsp_req;
    logic  rsp_ack;
    logic  rsp_is_write;
    word_t rsp_tag;
    resp_t rsp_resp;
    addr_t rsp_addr;
    word_t rsp_data;
    logic  executed;

    udp_cmd_parser u_parser (
        .gmii_rx_clk   (gmii_rx_clk  ),
        .arst_n        (arst_n       ),
        .rec_en        (rec_en       ),
        .rec_data      (rec_data     ),
        .rec_pkt_done  (rec_pkt_done ),
        .full          (full         ),
        .push          (push         ),
        .push_is_write (push_is_write),
        .push_tag      (push_tag     ),
        .push_addr     (push_addr    ),
        .push_data     (push_data    )
    );

    udp_cmd_queue u_queue (
        .gmii_rx_clk   (gmii_rx_clk  ),
        .arst_n        (arst_n       ),
        .push          (push         ),
        .push_is_write (push_is_write),
        .push_tag      (push_tag     ),
        .push_addr     (push_addr    ),
        .push_data     (push_data    ),
        .pop           (pop          ),
        .full          (full         ),
        .empty         (empty        ),
        .head_is_write (head_is_write),
        .head_tag      (head_tag     ),
        .head_addr     (head_addr    ),
        .head_data     (head_data    )
    );

    axi_cmd_executor u_executor (
        .gmii_rx_clk   (gmii_rx_clk  ),
        .arst_n        (arst_n       ),
        .empty         (empty        ),
        .head_is_write (head_is_write),
        .head_tag      (head_tag     ),
        .head_addr     (head_addr    ),
        .head_data     (head_data    ),
        .pop           (pop          ),
        .aw_addr       (aw_addr      ),
        .aw_valid      (aw_valid     ),
        .aw_ready      (aw_ready     ),
        .w_data        (w_data       ),
        .w_valid       (w_valid      ),
        .w_ready       (w_ready      ),
        .b_resp        (b_resp       ),
        .b_valid       (b_valid      ),
        .b_ready       (b_ready      ),
        .ar_addr       (ar_addr      ),
        .ar_valid      (ar_valid     ),
        .ar_ready      (ar_ready     ),
        .r_data        (r_data       ),
        .r_resp        (r_resp       ),
        .r_valid       (r_valid      ),
        .r_ready       (r_ready      ),
        .rsp_req       (rsp_req      ),
        .rsp_ack       (rsp_ack      ),
        .rsp_is_write  (rsp_is_write ),
        .rsp_tag       (rsp_tag      ),
        .rsp_resp      (rsp_resp     ),
        .rsp_addr      (rsp_addr     ),
        .rsp_data      (rsp_data     ),
        .executed      (executed     )
    );

    udp_reply_sender u_reply (
        .gmii_rx_clk   (gmii_rx_clk  ),
        .arst_n        (arst_n       ),
        .rsp_req       (rsp_req      ),
        .rsp_ack       (rsp_ack      ),
        .rsp_is_write  (rsp_is_write ),
        .rsp_tag       (rsp_tag      ),
        .rsp_resp      (rsp_resp     ),
        .rsp_addr      (rsp_addr     ),
        .rsp_data      (rsp_data     ),
        .tx_start_en   (tx_start_en  ),
        .tx_byte_num   (tx_byte_num  ),
        .tx_req        (tx_req       ),
        .tx_data       (tx_data      ),
        .tx_done       (tx_done      )
    );

    always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            udp_led <= '0;
        end else if (executed) begin
            udp_led <= udp_led + 8'd1; // executed commands, wraps
        end
    end

endmodule

`default_nettype wire

// File: verilog/udp_cmd_defines.svh
`ifndef UDP_CMD_DEFINES_SVH
`define UDP_CMD_DEFINES_SVH

// command queue slots, power of two
`define CMD_QUEUE_DEPTH 4
`define CMD_QUEUE_PTR_W 2

// reply length in words, header + address (+ read data)
`define REPLY_WORDS_WR 2
`define REPLY_WORDS_RD 3

`endif

// File: verilog/udp_cmd_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_cmd_parser (
    input  wire                     gmii_rx_clk,
    input  wire                     arst_n,
    input  wire                     rec_en,
    input  wire udp_cmd_pkg::word_t rec_data,
    input  wire                     rec_pkt_done,
    input  wire                     full,
    output logic                    push,
    output logic                    push_is_write,
    output udp_cmd_pkg::word_t      push_tag,
    output udp_cmd_pkg::addr_t      push_addr,
    output udp_cmd_pkg::word_t      push_data
);
    import udp_cmd_pkg::*;

    parse_state_t state;
    opcode_t      opcode;

    assign opcode = opcode_t'(rec_data[31:24]);

    always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= HEADER;
            push  <= 1'b0;
        end else begin
            push <= 1'b0;
            if (rec_pkt_done) begin
                state <= HEADER; // drops a partial command
            end else if (rec_en) begin
                case (state)
                    HEADER: begin
                        if (opcode == OP_WRITE || opcode == OP_READ) begin
                            state <= ADDR;
                        end
                    end
                    ADDR: begin
                        if (push_is_write) begin
                            state <= DATA;
                        end else begin
                            state <= HEADER;
                            push  <= !full; // full queue drops it
                        end
                    end
                    default: begin
                        state <= HEADER;
                        push  <= !full;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (rec_en) begin
            case (state)
                HEADER: begin
                    push_tag      <= rec_data;
                    push_is_write <= (opcode == OP_WRITE);
                end
                ADDR:    push_addr <= rec_data;
                default: push_data <= rec_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/udp_cmd_pkg.sv
`default_nettype none

package udp_cmd_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [1:0]  resp_t;     // axi bresp/rresp
    typedef logic [15:0] byte_num_t; // udp payload bytes

    typedef enum logic [7:0] {
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02
    } opcode_t;

    typedef enum logic [1:0] {HEADER, ADDR, DATA} parse_state_t;

    typedef enum logic [2:0] {
        IDLE, WR_ADDR, WR_RESP, RD_ADDR, RD_DATA, HANDOFF
    } exec_state_t;

    // prefixed so they do not clash with the executor's IDLE
    typedef enum logic [1:0] {RPL_IDLE, RPL_START, RPL_SEND, RPL_DONE} reply_state_t;

endpackage

`default_nettype wire

// File: verilog/udp_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_cmd_defines.svh"

module udp_cmd_queue (
    input  wire                     gmii_rx_clk,
    input  wire                     arst_n,
    input  wire                     push,
    input  wire                     push_is_write,
    input  wire udp_cmd_pkg::word_t push_tag,
    input  wire udp_cmd_pkg::addr_t push_addr,
    input  wire udp_cmd_pkg::word_t push_data,
    input  wire                     pop,
    output logic                    full,
    output logic                    empty,
    output logic                    head_is_write,
    output udp_cmd_pkg::word_t      head_tag,
    output udp_cmd_pkg::addr_t      head_addr,
    output udp_cmd_pkg::word_t      head_data
);
    import udp_cmd_pkg::*;

    logic                         is_write_mem [`CMD_QUEUE_DEPTH];
    word_t                        tag_mem      [`CMD_QUEUE_DEPTH];
    addr_t                        addr_mem     [`CMD_QUEUE_DEPTH];
    word_t                        data_mem     [`CMD_QUEUE_DEPTH];
    logic [`CMD_QUEUE_PTR_W-1:0]  wr_ptr;
    logic [`CMD_QUEUE_PTR_W-1:0]  rd_ptr;
    logic [`CMD_QUEUE_PTR_W:0]    count;
    logic                         wr_en;
    logic                         rd_en;

    assign full  = (count == `CMD_QUEUE_DEPTH);
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign head_is_write = is_write_mem[rd_ptr];
    assign head_tag      = tag_mem[rd_ptr];
    assign head_addr     = addr_mem[rd_ptr];
    assign head_data     = data_mem[rd_ptr];

    always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (wr_en) begin
            is_write_mem[wr_ptr] <= push_is_write;
            tag_mem[wr_ptr]      <= push_tag;
            addr_mem[wr_ptr]     <= push_addr;
            data_mem[wr_ptr]     <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/udp_reply_sender.sv
`timescale 1ns/1ps
`default_nettype none
`include "udp_cmd_defines.svh"

module udp_reply_sender (
    input  wire                     gmii_rx_clk,
    input  wire                     arst_n,
    input  wire                     rsp_req,
    output logic                    rsp_ack,
    input  wire                     rsp_is_write,
    input  wire udp_cmd_pkg::word_t rsp_tag,
    input  wire udp_cmd_pkg::resp_t rsp_resp,
    input  wire udp_cmd_pkg::addr_t rsp_addr,
    input  wire udp_cmd_pkg::word_t rsp_data,
    output logic                    tx_start_en,
    output udp_cmd_pkg::byte_num_t  tx_byte_num,
    input  wire                     tx_req,
    output udp_cmd_pkg::word_t      tx_data,
    input  wire                     tx_done
);
    import udp_cmd_pkg::*;

    reply_state_t state;
    word_t        reply_word [`REPLY_WORDS_RD];
    logic [1:0]   word_idx;
    logic         take;

    assign take = (state == RPL_IDLE) && rsp_req && !rsp_ack;

    always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= RPL_IDLE;
            rsp_ack     <= 1'b0;
            tx_start_en <= 1'b0;
            word_idx    <= '0;
        end else begin
            tx_start_en <= 1'b0;
            case (state)
                RPL_IDLE: begin
                    if (take) begin
                        rsp_ack  <= 1'b1;
                        word_idx <= '0;
                        state    <= RPL_START;
                    end
                end
                RPL_START: begin
                    tx_start_en <= 1'b1; // single cycle
                    state       <= RPL_SEND;
                end
                RPL_SEND: begin
                    if (tx_req) word_idx <= word_idx + 1'b1;
                    if (tx_done && !rsp_req) begin
                        rsp_ack <= 1'b0;
                        state   <= RPL_IDLE;
                    end else if (tx_done) begin
                        state <= RPL_DONE; // req still up
                    end
                end
                default: begin
                    if (!rsp_req) begin
                        rsp_ack <= 1'b0;
                        state   <= RPL_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (take) begin
            reply_word[0] <= {rsp_tag[31:2], rsp_resp}; // resp in low bits
            reply_word[1] <= rsp_addr;
            reply_word[2] <= rsp_data;
            tx_byte_num   <= rsp_is_write ? byte_num_t'(`REPLY_WORDS_WR * 4)
                                          : byte_num_t'(`REPLY_WORDS_RD * 4);
        end
        if (state == RPL_SEND && tx_req) tx_data <= reply_word[word_idx];
    end

endmodule

`default_nettype wire
